// File: logic/fifo_pkg.sv
package fifo_pkg;

    // fifo geometry
    localparam int FIFO_DEPTH = 64;                   // entries in each sram slice
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);   // sram address, 6 bits
    localparam int LEVEL_W    = $clog2(FIFO_DEPTH + 1); // holds 0..64, 7 bits

    // slice geometry, one 64x6 register-file macro per slice
    localparam int SLICE_W    = 6;                    // bits per macro
    localparam int NUM_SLICES = 4;                    // macros side by side
    localparam int DATA_W     = SLICE_W * NUM_SLICES; // user word, 24 bits

    // one data word, two views of the same 24 bits
    // flat is what the user pushes and pops
    // slices is how the word is cut across the macros, slice 0 = low bits
    typedef union packed {
        logic [DATA_W-1:0]                  flat;   // user view
        logic [NUM_SLICES-1:0][SLICE_W-1:0] slices; // per-macro view
    } fifo_word_u;

endpackage

// File: logic/fifo_rd_ctrl.sv
`timescale 1ns/10ps

module fifo_rd_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rd_en,           // pop request, level
    input  logic                         sram_wr_cen,     // low = push accepted
    output logic                         sram_rd_cen,     // active low read strobe
    output logic [fifo_pkg::ADDR_W-1:0]  sram_rd_a,       // read address to all slices
    output logic                         full,
    output logic                         empty,
    output logic [fifo_pkg::LEVEL_W-1:0] empty_entry_num, // free entries
    output logic                         undflow          // pop refused, one cycle late
);

    import fifo_pkg::*;

    logic               wr_acc;    // push seen by write ctrl
    logic               rd_acc;    // pop accepted this cycle
    logic [ADDR_W-1:0]  rd_ptr;    // oldest stored entry
    logic [LEVEL_W-1:0] count;     // occupancy, 0..64
    logic [LEVEL_W-1:0] count_nxt; // occupancy after this edge

    // write strobe doubles as the accept signal, so full is tested once only
    assign wr_acc      = ~sram_wr_cen;
    assign rd_acc      = rd_en & ~empty;         // only empty test in the design
    assign sram_rd_cen = ~rd_acc;                // low active like the macro
    assign sram_rd_a   = rd_ptr;                 // data shows on rd_q after the edge

    // next occupancy
    always_comb begin
        case ({wr_acc, rd_acc})
            2'b10:   count_nxt = count + LEVEL_W'(1); // push only
            2'b01:   count_nxt = count - LEVEL_W'(1); // pop only
            default: count_nxt = count;               // none, or both at once
        endcase
    end

    // read pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_acc) begin
            rd_ptr <= rd_ptr + ADDR_W'(1);       // wraps modulo depth
        end
    end

    // occupancy counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count_nxt;
        end
    end

    // flags come from count_nxt so they move on the same edge as count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full            <= 1'b0;
            empty           <= 1'b1;                  // nothing stored
            empty_entry_num <= LEVEL_W'(FIFO_DEPTH);  // all 64 free
        end else begin
            full            <= (count_nxt == LEVEL_W'(FIFO_DEPTH));
            empty           <= (count_nxt == '0);
            empty_entry_num <= LEVEL_W'(FIFO_DEPTH) - count_nxt;
        end
    end

    // underflow pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            undflow <= 1'b0;
        end else begin
            undflow <= rd_en & empty;            // refused pop, one cycle
        end
    end

endmodule

// File: logic/fifo_wr_ctrl.sv
`timescale 1ns/10ps

module fifo_wr_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_en,       // push request, level
    input  logic                        full,        // registered in read ctrl
    output logic                        sram_wr_cen, // active low write strobe
    output logic [fifo_pkg::ADDR_W-1:0] sram_wr_a,   // write address to all slices
    output logic                        ovflow       // push refused, one cycle late
);

    import fifo_pkg::*;

    logic              wr_acc;  // push accepted this cycle
    logic [ADDR_W-1:0] wr_ptr;  // next free entry

    // the only full test in the design lives here
    assign wr_acc      = wr_en & ~full;          // dropped when full, pop or not
    assign sram_wr_cen = ~wr_acc;                // macro strobe is low active
    assign sram_wr_a   = wr_ptr;                 // write lands at current pointer

    // pointer moves on the accepting edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;                        // start at entry 0
        end else if (wr_acc) begin
            wr_ptr <= wr_ptr + ADDR_W'(1);       // wraps 63 -> 0 by width
        end
    end

    // overflow pulse, registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovflow <= 1'b0;
        end else begin
            ovflow <= wr_en & full;              // high for one cycle per refused push
        end
    end

endmodule

// File: logic/pciei_sync_fifo_2psram.sv
`timescale 1ns/10ps

module pciei_sync_fifo_2psram (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         wr_en,           // push
    input  logic [fifo_pkg::DATA_W-1:0]  din,
    output logic                         full,

    input  logic                         rd_en,           // pop
    output logic [fifo_pkg::DATA_W-1:0]  dout,            // valid the cycle after pop
    output logic                         empty,
    output logic [fifo_pkg::LEVEL_W-1:0] empty_entry_num, // free entries

    output logic                         ovflow,          // push while full
    output logic                         undflow          // pop while empty
);

    import fifo_pkg::*;

    logic              sram_wr_cen; // shared by all slices
    logic [ADDR_W-1:0] sram_wr_a;
    logic              sram_rd_cen;
    logic [ADDR_W-1:0] sram_rd_a;
    fifo_word_u        din_w;       // din cut into slices
    fifo_word_u        dout_w;      // slice outputs joined back

    assign din_w.flat = din;
    assign dout       = dout_w.flat;

    // write side, qualifies push against full
    fifo_wr_ctrl u_fifo_wr_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .full        (full),
        .sram_wr_cen (sram_wr_cen),
        .sram_wr_a   (sram_wr_a),
        .ovflow      (ovflow)
    );

    // read side, owns the count and all level flags
    fifo_rd_ctrl u_fifo_rd_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_en           (rd_en),
        .sram_wr_cen     (sram_wr_cen),     // accepted push
        .sram_rd_cen     (sram_rd_cen),
        .sram_rd_a       (sram_rd_a),
        .full            (full),
        .empty           (empty),
        .empty_entry_num (empty_entry_num),
        .undflow         (undflow)
    );

    // 24-bit word built from four 64x6 macros, same strobes and addresses
    for (genvar gi = 0; gi < NUM_SLICES; gi++) begin : g_slice
        sram_2p_slice u_sram_2p_slice (
            .clk    (clk),
            .rst_n  (rst_n),
            .wr_cen (sram_wr_cen),
            .wr_a   (sram_wr_a),
            .wr_d   (din_w.slices[gi]),   // slice 0 = din[5:0]
            .rd_cen (sram_rd_cen),
            .rd_a   (sram_rd_a),
            .rd_q   (dout_w.slices[gi])   // back into the same bit range
        );
    end

endmodule

// File: logic/sram_2p_slice.sv
`timescale 1ns/10ps

module sram_2p_slice (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_cen, // low = write this edge
    input  logic [fifo_pkg::ADDR_W-1:0]  wr_a,
    input  logic [fifo_pkg::SLICE_W-1:0] wr_d,
    input  logic                         rd_cen, // low = read this edge
    input  logic [fifo_pkg::ADDR_W-1:0]  rd_a,
    output logic [fifo_pkg::SLICE_W-1:0] rd_q    // registered read data
);

    import fifo_pkg::*;

    logic [SLICE_W-1:0] mem [FIFO_DEPTH]; // 64x6 storage array

    // write port
    always_ff @(posedge clk) begin
        if (!wr_cen) begin
            mem[wr_a] <= wr_d;             // lands at the edge
        end
    end

    // read port, one cycle latency, holds while rd_cen is high
    // same-edge write to rd_a returns the old content, as a real macro would
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= '0;                    // dout reads 0 out of reset
        end else if (!rd_cen) begin
            rd_q <= mem[rd_a];
        end
    end

endmodule

// File: pciei_sync_fifo_2psram.f
logic/fifo_pkg.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/sram_2p_slice.sv
logic/pciei_sync_fifo_2psram.sv
tests/pciei_sync_fifo_2psram_chk.sv
tests/tb_pciei_sync_fifo_2psram.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -Mdir obj_dir \
    --top-module tb_pciei_sync_fifo_2psram \
    -f pciei_sync_fifo_2psram.f \
    -o sim_tb

./obj_dir/sim_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// File: tests/pciei_sync_fifo_2psram_chk.sv
`timescale 1ns/10ps

module pciei_sync_fifo_2psram_chk (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         wr_en,
    input logic                         rd_en,
    input logic                         full,
    input logic                         empty,
    input logic [fifo_pkg::LEVEL_W-1:0] empty_entry_num,
    input logic                         ovflow,
    input logic                         undflow
);

    import fifo_pkg::*;

    // never both at once
    a_full_empty_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(full && empty))
        else $error("full and empty high together");

    // pulse only after a refused push
    a_ovflow_cause : assert property (@(posedge clk) disable iff (!rst_n)
        ovflow |-> $past(wr_en && full))
        else $error("ovflow without a push while full");

    // pulse only after a refused pop
    a_undflow_cause : assert property (@(posedge clk) disable iff (!rst_n)
        undflow |-> $past(rd_en && empty))
        else $error("undflow without a pop while empty");

    // empty flag and free count agree
    a_empty_level : assert property (@(posedge clk) disable iff (!rst_n)
        empty == (empty_entry_num == LEVEL_W'(FIFO_DEPTH)))
        else $error("empty disagrees with empty_entry_num");

endmodule

bind pciei_sync_fifo_2psram pciei_sync_fifo_2psram_chk pciei_sync_fifo_2psram_chk_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_en           (wr_en),
    .rd_en           (rd_en),
    .full            (full),
    .empty           (empty),
    .empty_entry_num (empty_entry_num),
    .ovflow          (ovflow),
    .undflow         (undflow)
);

// File: tests/tb_pciei_sync_fifo_2psram.sv
`timescale 1ns/10ps

module tb_pciei_sync_fifo_2psram;

    import fifo_pkg::*;

    localparam int CLK_PERIOD    = 8;    // ns
    localparam int RESET_CYCLES  = 8;
    localparam int SEED          = 83;
    localparam int ORDER_WORDS   = 10;
    localparam int MIXED_CYCLES  = 300;
    // order: push + pop + idle, fill: fill + extra push + idle + drain,
    // empty pop: 2, mixed: random run + worst case drain
    localparam int TEST_CYCLES   = RESET_CYCLES + (2 * ORDER_WORDS + 1)
                                 + (2 * FIFO_DEPTH + 2) + 2
                                 + (MIXED_CYCLES + FIFO_DEPTH);
    localparam int MARGIN_CYCLES = 200;

    logic               clk;
    logic               rst_n;
    logic               wr_en;
    logic [DATA_W-1:0]  din;
    logic               full;
    logic               rd_en;
    logic [DATA_W-1:0]  dout;
    logic               empty;
    logic [LEVEL_W-1:0] empty_entry_num;
    logic               ovflow;
    logic               undflow;

    logic [DATA_W-1:0]  ref_q [$];   // words the fifo should hold, oldest first
    logic [DATA_W-1:0]  exp_dout;    // last word popped by the model
    logic               exp_ovf;     // model pulses
    logic               exp_udf;
    int                 err_cnt;
    int                 chk_cnt;
    int unsigned        seed_ret;

    pciei_sync_fifo_2psram pciei_sync_fifo_2psram_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_en           (wr_en),
        .din             (din),
        .full            (full),
        .rd_en           (rd_en),
        .dout            (dout),
        .empty           (empty),
        .empty_entry_num (empty_entry_num),
        .ovflow          (ovflow),
        .undflow         (undflow)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;       // 8 ns period
    end

    // watchdog, sized from the test lengths above
    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
        $display("timeout: tests still running after %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR @%0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // every output against the reference model
    task automatic compare_outputs();
        check_value("dout", 32'(dout), 32'(exp_dout));
        check_value("empty", 32'(empty), 32'(ref_q.size() == 0));
        check_value("full", 32'(full), 32'(ref_q.size() == FIFO_DEPTH));
        check_value("empty_entry_num", 32'(empty_entry_num),
                    32'(FIFO_DEPTH - ref_q.size()));
        check_value("ovflow", 32'(ovflow), 32'(exp_ovf));
        check_value("undflow", 32'(undflow), 32'(exp_udf));
    endtask

    // one clock edge; model follows the fifo rules, outputs checked 1 ns later
    task automatic advance_cycle();
        bit push_ok;
        bit pop_ok;
        @(posedge clk);
        push_ok = wr_en && (ref_q.size() < FIFO_DEPTH); // dropped when full
        pop_ok  = rd_en && (ref_q.size() > 0);
        exp_ovf = wr_en && (ref_q.size() == FIFO_DEPTH);
        exp_udf = rd_en && (ref_q.size() == 0);
        if (pop_ok) begin
            exp_dout = ref_q.pop_front();              // shows on dout after this edge
        end
        if (push_ok) begin
            ref_q.push_back(din);
        end
        #1;                                           // outputs settled, inputs go next
        compare_outputs();
    endtask

    task automatic push_word(input logic [DATA_W-1:0] word);
        wr_en = 1'b1;
        rd_en = 1'b0;
        din   = word;
        advance_cycle();
        wr_en = 1'b0;
    endtask

    task automatic pop_word();
        wr_en = 1'b0;
        rd_en = 1'b1;
        advance_cycle();
        rd_en = 1'b0;
    endtask

    task automatic idle_cycle();
        wr_en = 1'b0;
        rd_en = 1'b0;
        advance_cycle();
    endtask

    task automatic drain_fifo();
        while (ref_q.size() > 0) begin
            pop_word();
        end
    endtask

    // four different slice values, built bit by bit, slice 0 in the low bits
    function automatic logic [DATA_W-1:0] distinct_slice_word();
        int unsigned       base;
        int unsigned       stride;
        logic [DATA_W-1:0] word;
        base   = $urandom % 64;
        stride = 2 * ($urandom % 16) + 1;             // odd, so no two slices match
        word   = '0;
        for (int i = 0; i < NUM_SLICES; i++) begin
            word[i*SLICE_W +: SLICE_W] = SLICE_W'(base + i * stride);
        end
        return word;
    endfunction

    task automatic reset_values();
        $display("reset values");
        compare_outputs();                            // empty, 64 free, dout 0
    endtask

    task automatic order_and_slices();
        logic [DATA_W-1:0] words [ORDER_WORDS];
        $display("order and slice mapping");
        for (int i = 0; i < ORDER_WORDS; i++) begin
            words[i] = distinct_slice_word();
            push_word(words[i]);
        end
        for (int i = 0; i < ORDER_WORDS; i++) begin
            pop_word();
            check_value("popped word", 32'(dout), 32'(words[i])); // cycle after pop
        end
        idle_cycle();
    endtask

    task automatic fill_and_overflow();
        logic [DATA_W-1:0] first_words [$];
        logic [DATA_W-1:0] word;
        $display("fill and overflow");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            word = DATA_W'($urandom);
            first_words.push_back(word);
            push_word(word);
        end
        check_value("full after last push", 32'(full), 32'd1);
        check_value("free entries when full", 32'(empty_entry_num), 32'd0);
        push_word(DATA_W'($urandom));                 // refused
        check_value("ovflow on push into full", 32'(ovflow), 32'd1);
        idle_cycle();
        check_value("ovflow one cycle only", 32'(ovflow), 32'd0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pop_word();
            check_value("drained word", 32'(dout), 32'(first_words[i]));
        end
        check_value("empty after drain", 32'(empty), 32'd1);
    endtask

    task automatic pop_when_empty();
        logic [DATA_W-1:0] last_word;
        $display("pop when empty");
        last_word = exp_dout;                         // last word the model popped
        pop_word();
        check_value("undflow on empty pop", 32'(undflow), 32'd1);
        check_value("dout held on empty pop", 32'(dout), 32'(last_word));
        check_value("free entries on empty pop", 32'(empty_entry_num), 32'(FIFO_DEPTH));
        idle_cycle();
        check_value("undflow one cycle only", 32'(undflow), 32'd0);
    endtask

    task automatic mixed_traffic();
        $display("mixed traffic");
        for (int cyc = 0; cyc < MIXED_CYCLES; cyc++) begin
            if (cyc < MIXED_CYCLES / 3) begin
                wr_en = ($urandom % 8) != 0;          // writes lead, reaches full
                rd_en = ($urandom % 8) == 0;
            end else if (cyc < 2 * MIXED_CYCLES / 3) begin
                wr_en = ($urandom % 2) != 0;          // balanced
                rd_en = ($urandom % 2) != 0;
            end else begin
                wr_en = ($urandom % 8) == 0;          // reads lead, reaches empty
                rd_en = ($urandom % 8) != 0;
            end
            din = DATA_W'($urandom);
            advance_cycle();
        end
        wr_en = 1'b0;
        rd_en = 1'b0;
        drain_fifo();                                 // leftovers still in order
    endtask

    initial begin
        seed_ret = $urandom(SEED);                    // one seed for the whole run
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        rd_en    = 1'b0;
        din      = '0;
        exp_dout = '0;
        exp_ovf  = 1'b0;
        exp_udf  = 1'b0;
        err_cnt  = 0;
        chk_cnt  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_values();
        order_and_slices();
        fill_and_overflow();
        pop_when_empty();
        mixed_traffic();

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
